/* Makefile */
# Verilator build and run for the DDR link receive testbench

VERILATOR ?= verilator
TOP       ?= ddr_link_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE) -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* design/ddr_link_cdc_fifo.sv */
/*
 * Dual-clock beat FIFO
 * Moves beats from a channel clock into the core clock
 * using Gray-coded pointers and two-flop synchronizers
 */
module ddr_link_cdc_fifo (
  input  logic                             wr_clk_i,
  input  logic                             rd_clk_i,
  input  logic                             arst_n_i,
  input  logic [ddr_link_pkg::DDR_WIDTH-1:0] wr_data_i,
  input  logic                             wr_en_i,
  output logic [ddr_link_pkg::DDR_WIDTH-1:0] rd_data_o,
  output logic                             rd_valid_o,
  input  logic                             rd_yumi_i
);
  import ddr_link_pkg::*;

  logic [DDR_WIDTH-1:0] mem_r [(1 << LG_FIFO_DEPTH)];

  // Binary pointers carry one extra wrap bit
  logic [LG_FIFO_DEPTH:0] wr_ptr_r;
  logic [LG_FIFO_DEPTH:0] wr_ptr_next;
  logic [LG_FIFO_DEPTH:0] wr_gray_r;
  logic [LG_FIFO_DEPTH:0] rd_ptr_r;
  logic [LG_FIFO_DEPTH:0] rd_ptr_next;
  logic [LG_FIFO_DEPTH:0] rd_gray_r;

  // Write pointer seen by the read side
  logic [LG_FIFO_DEPTH:0] wr_gray_meta_r;
  logic [LG_FIFO_DEPTH:0] wr_gray_sync_r;

  // Read pointer seen by the write side
  logic [LG_FIFO_DEPTH:0] rd_gray_meta_r;
  logic [LG_FIFO_DEPTH:0] rd_gray_sync_r;

  logic wr_space;
  logic wr_push;

  // Write domain
  // Space check only; the credit loop keeps writes within depth
  assign wr_space = wr_gray_r != {~rd_gray_sync_r[LG_FIFO_DEPTH -: 2],
                                  rd_gray_sync_r[LG_FIFO_DEPTH-2:0]};
  assign wr_push     = wr_en_i & wr_space;
  assign wr_ptr_next = wr_ptr_r + 1'b1;

  always_ff @(posedge wr_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_r       <= '0;
      wr_gray_r      <= '0;
      rd_gray_meta_r <= '0;
      rd_gray_sync_r <= '0;
    end
    else
    begin
      if (wr_push)
      begin
        wr_ptr_r  <= wr_ptr_next;
        wr_gray_r <= wr_ptr_next ^ (wr_ptr_next >> 1);
      end
      rd_gray_meta_r <= rd_gray_r;
      rd_gray_sync_r <= rd_gray_meta_r;
    end
  end

  always_ff @(posedge wr_clk_i)
  begin
    if (wr_push)
    begin
      mem_r[wr_ptr_r[LG_FIFO_DEPTH-1:0]] <= wr_data_i;
    end
  end

  // Read domain
  assign rd_ptr_next = rd_ptr_r + 1'b1;

  always_ff @(posedge rd_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rd_ptr_r       <= '0;
      rd_gray_r      <= '0;
      wr_gray_meta_r <= '0;
      wr_gray_sync_r <= '0;
    end
    else
    begin
      if (rd_yumi_i)
      begin
        rd_ptr_r  <= rd_ptr_next;
        rd_gray_r <= rd_ptr_next ^ (rd_ptr_next >> 1);
      end
      wr_gray_meta_r <= wr_gray_r;
      wr_gray_sync_r <= wr_gray_meta_r;
    end
  end

  // Not empty as seen through the synchronized write pointer
  assign rd_valid_o = rd_gray_r != wr_gray_sync_r;
  assign rd_data_o  = mem_r[rd_ptr_r[LG_FIFO_DEPTH-1:0]];

endmodule

/* design/ddr_link_channel_rx.sv */
/*
 * Channel receiver
 * Buffers one channel's beats across into the core clock
 * and returns decimated credit tokens to the transmitter
 */
module ddr_link_channel_rx (
  input  logic                             io_clk_i,
  input  logic                             core_clk_i,
  input  logic                             arst_n_i,
  input  logic [ddr_link_pkg::DDR_WIDTH-1:0] beat_data_i,
  input  logic                             beat_valid_i,
  output logic [ddr_link_pkg::DDR_WIDTH-1:0] ch_data_o,
  output logic                             ch_valid_o,
  input  logic                             ch_yumi_i,
  output logic                             io_token_r_o
);
  import ddr_link_pkg::*;

  logic [LG_TOKEN_DECIMATION-1:0] deq_count_r;
  logic                           token_req_r;
  logic                           token_meta_r;
  logic                           token_sync_r;
  logic                           token_prev_r;

  ddr_link_cdc_fifo fifo_i (
    .wr_clk_i   (io_clk_i),
    .rd_clk_i   (core_clk_i),
    .arst_n_i   (arst_n_i),
    .wr_data_i  (beat_data_i),
    .wr_en_i    (beat_valid_i),
    .rd_data_o  (ch_data_o),
    .rd_valid_o (ch_valid_o),
    .rd_yumi_i  (ch_yumi_i)
  );

  // Count dequeues; flip the request on every wrap of the counter
  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      deq_count_r <= '0;
      token_req_r <= 1'b0;
    end
    else if (ch_yumi_i)
    begin
      deq_count_r <= deq_count_r + 1'b1;
      if (&deq_count_r)
      begin
        token_req_r <= ~token_req_r;
      end
    end
  end

  // Request level crosses into the io clock, then an edge toggles the token
  always_ff @(posedge io_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      token_meta_r <= 1'b0;
      token_sync_r <= 1'b0;
      token_prev_r <= 1'b0;
      io_token_r_o <= 1'b0;
    end
    else
    begin
      token_meta_r <= token_req_r;
      token_sync_r <= token_meta_r;
      token_prev_r <= token_sync_r;
      io_token_r_o <= io_token_r_o ^ (token_sync_r ^ token_prev_r);
    end
  end

endmodule

/* design/ddr_link_downstream.sv */
/*
 * DDR link receive top
 * Per channel capture and clock crossing, then packet assembly for the core
 */
module ddr_link_downstream (
  input  logic                                                          core_clk_i,
  input  logic                                                          arst_n_i,
  input  logic [ddr_link_pkg::NUM_CHANNELS-1:0]                           io_clk_i,
  input  logic [ddr_link_pkg::NUM_CHANNELS-1:0][ddr_link_pkg::CHANNEL_WIDTH-1:0] io_data_i,
  input  logic [ddr_link_pkg::NUM_CHANNELS-1:0]                           io_valid_i,
  output logic [ddr_link_pkg::NUM_CHANNELS-1:0]                           io_token_r_o,
  output logic [ddr_link_pkg::PACKET_WIDTH-1:0]                           core_data_o,
  output logic                                                          core_valid_o,
  input  logic                                                          core_yumi_i
);
  import ddr_link_pkg::*;

  // Core side of every channel
  logic [NUM_CHANNELS-1:0][DDR_WIDTH-1:0] ch_data;
  logic [NUM_CHANNELS-1:0]                ch_valid;
  logic                                   ch_yumi;

  for (genvar i = 0; i < NUM_CHANNELS; i++)
  begin : g_ch
    logic [DDR_WIDTH-1:0] beat_data;
    logic                 beat_valid;

    ddr_link_iddr_capture capture_i (
      .io_clk_i     (io_clk_i[i]),
      .arst_n_i     (arst_n_i),
      .io_data_i    (io_data_i[i]),
      .io_valid_i   (io_valid_i[i]),
      .beat_data_o  (beat_data),
      .beat_valid_o (beat_valid)
    );

    ddr_link_channel_rx rx_i (
      .io_clk_i     (io_clk_i[i]),
      .core_clk_i   (core_clk_i),
      .arst_n_i     (arst_n_i),
      .beat_data_i  (beat_data),
      .beat_valid_i (beat_valid),
      .ch_data_o    (ch_data[i]),
      .ch_valid_o   (ch_valid[i]),
      .ch_yumi_i    (ch_yumi),
      .io_token_r_o (io_token_r_o[i])
    );
  end

  // One shared yumi keeps the channels aligned
  ddr_link_packet_sipo sipo_i (
    .core_clk_i   (core_clk_i),
    .arst_n_i     (arst_n_i),
    .ch_data_i    (ch_data),
    .ch_valid_i   (ch_valid),
    .ch_yumi_o    (ch_yumi),
    .core_data_o  (core_data_o),
    .core_valid_o (core_valid_o),
    .core_yumi_i  (core_yumi_i)
  );

endmodule

/* design/ddr_link_iddr_capture.sv */
/*
 * DDR input capture
 * Samples one channel on both edges of its forwarded clock
 * and presents the two halves as a single beat
 */
module ddr_link_iddr_capture (
  input  logic                                 io_clk_i,
  input  logic                                 arst_n_i,
  input  logic [ddr_link_pkg::CHANNEL_WIDTH-1:0] io_data_i,
  input  logic                                 io_valid_i,
  output logic [ddr_link_pkg::DDR_WIDTH-1:0]     beat_data_o,
  output logic                                 beat_valid_o
);
  import ddr_link_pkg::*;

  logic [CHANNEL_WIDTH-1:0] rise_data_r;
  logic                     rise_valid_r;
  logic [CHANNEL_WIDTH-1:0] fall_data_r;

  // Rising edge half, low byte of the beat
  always_ff @(posedge io_clk_i)
  begin
    rise_data_r <= io_data_i;
  end

  // Falling edge half, high byte of the beat
  always_ff @(negedge io_clk_i)
  begin
    fall_data_r <= io_data_i;
  end

  always_ff @(posedge io_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rise_valid_r <= 1'b0;
      beat_valid_o <= 1'b0;
    end
    else
    begin
      rise_valid_r <= io_valid_i;
      beat_valid_o <= rise_valid_r;
    end
  end

  // Join on the rising edge after the falling half has landed
  always_ff @(posedge io_clk_i)
  begin
    beat_data_o <= {fall_data_r, rise_data_r};
  end

endmodule

/* design/ddr_link_packet_sipo.sv */
/*
 * Packet assembler
 * Takes one aligned group of channel beats per cycle and
 * shifts it into a full core packet, presented with valid/yumi
 */
module ddr_link_packet_sipo (
  input  logic                                                        core_clk_i,
  input  logic                                                        arst_n_i,
  input  logic [ddr_link_pkg::NUM_CHANNELS-1:0][ddr_link_pkg::DDR_WIDTH-1:0] ch_data_i,
  input  logic [ddr_link_pkg::NUM_CHANNELS-1:0]                         ch_valid_i,
  output logic                                                        ch_yumi_o,
  output logic [ddr_link_pkg::PACKET_WIDTH-1:0]                         core_data_o,
  output logic                                                        core_valid_o,
  input  logic                                                        core_yumi_i
);
  import ddr_link_pkg::*;

  logic [$clog2(BEATS_PER_PACKET)-1:0] beat_cnt_r;
  logic                                full_r;
  logic [PACKET_WIDTH-1:0]             packet_r;
  logic                                last_beat;

  // Room when empty, or when the held packet leaves this cycle
  assign ch_yumi_o = (&ch_valid_i) & (~full_r | core_yumi_i);
  assign last_beat = int'(beat_cnt_r) == BEATS_PER_PACKET - 1;

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      beat_cnt_r <= '0;
      full_r     <= 1'b0;
    end
    else
    begin
      if (ch_yumi_o)
      begin
        if (last_beat)
        begin
          beat_cnt_r <= '0;
        end
        else
        begin
          beat_cnt_r <= beat_cnt_r + 1'b1;
        end
      end
      // Set wins over the clear from core_yumi_i
      if (ch_yumi_o && last_beat)
      begin
        full_r <= 1'b1;
      end
      else if (core_yumi_i)
      begin
        full_r <= 1'b0;
      end
    end
  end

  // Beat b lands at bit 32*b, channel c inside it at 16*c
  always_ff @(posedge core_clk_i)
  begin
    if (ch_yumi_o)
    begin
      packet_r[beat_cnt_r*(DDR_WIDTH*NUM_CHANNELS) +: DDR_WIDTH*NUM_CHANNELS] <= ch_data_i;
    end
  end

  assign core_data_o  = packet_r;
  assign core_valid_o = full_r;

endmodule

/* design/ddr_link_pkg.sv */
/*
 * DDR link package
 * Sizes of the receive link and its flow-control constants
 */
package ddr_link_pkg;

  // Data pins per channel
  localparam int CHANNEL_WIDTH = 8;

  // Number of forwarded-clock channels
  localparam int NUM_CHANNELS = 2;

  // Both edge halves joined into one beat
  localparam int DDR_WIDTH = 2 * CHANNEL_WIDTH;

  // Beats gathered from every channel per core packet
  localparam int BEATS_PER_PACKET = 2;

  // Core packet width
  localparam int PACKET_WIDTH = DDR_WIDTH * NUM_CHANNELS * BEATS_PER_PACKET;

  // Per-channel FIFO depth is 2**LG_FIFO_DEPTH
  // The transmitter starts with the same number of credits
  localparam int LG_FIFO_DEPTH = 3;

  // One token toggle per 2**LG_TOKEN_DECIMATION dequeued beats
  localparam int LG_TOKEN_DECIMATION = 2;

endpackage

/* sim.f */
design/ddr_link_pkg.sv
design/ddr_link_iddr_capture.sv
design/ddr_link_cdc_fifo.sv
design/ddr_link_channel_rx.sv
design/ddr_link_packet_sipo.sv
design/ddr_link_downstream.sv
verification/ddr_link_tb.sv

/* verification/ddr_link_tb.sv */
/*
 * DDR link receive testbench
 * Models the transmitter with credits and the core sink,
 * checks assembled packets against a scoreboard
 */
module ddr_link_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import ddr_link_pkg::*;

  localparam int CORE_PERIOD      = 20;
  localparam int IO_PERIOD        = 26;
  localparam int IO_PHASE         = 7;
  localparam int DRIVE_DELAY      = 2;
  localparam int SEED             = 60;
  localparam int FIFO_DEPTH       = 1 << LG_FIFO_DEPTH;
  localparam int TOKEN_BEATS      = 1 << LG_TOKEN_DECIMATION;
  localparam int HOLD_CYCLES      = 200;
  localparam int ASSEMBLY_PACKETS = 32;
  localparam int SKEW_PACKETS     = 16;
  localparam int HOLD_PACKETS     = 16;
  localparam int RANDOM_PACKETS   = 64;
  localparam int TOTAL_PACKETS    = ASSEMBLY_PACKETS + SKEW_PACKETS + HOLD_PACKETS
                                    + RANDOM_PACKETS;
  localparam int WATCHDOG_NS      = TOTAL_PACKETS * BEATS_PER_PACKET * IO_PERIOD * 4
                                    + HOLD_CYCLES * CORE_PERIOD + 10000;

  // Core sink modes
  localparam int YUMI_ALWAYS = 0;
  localparam int YUMI_RANDOM = 1;
  localparam int YUMI_HOLD   = 2;

  logic                                       core_clk_i;
  logic                                       arst_n_i;
  logic [NUM_CHANNELS-1:0]                    io_clk_i;
  logic [NUM_CHANNELS-1:0][CHANNEL_WIDTH-1:0] io_data_i;
  logic [NUM_CHANNELS-1:0]                    io_valid_i;
  logic [NUM_CHANNELS-1:0]                    io_token_r_o;
  logic [PACKET_WIDTH-1:0]                    core_data_o;
  logic                                       core_valid_o;
  logic                                       core_yumi_i;

  // Scoreboard and the beat stream of every channel
  logic [PACKET_WIDTH-1:0] exp_q [$];
  logic [DDR_WIDTH-1:0]    tx_q [NUM_CHANNELS][$];

  int    seed = SEED;
  int    yumi_mode = YUMI_ALWAYS;
  int    rx_count = 0;
  int    rx_err = 0;
  int    hold_err = 0;
  int    main_err = 0;
  int    tests_run = 0;
  int    tx_err_seen [NUM_CHANNELS];
  int    tok_seen [NUM_CHANNELS];
  string test_name = "reset";

  ddr_link_downstream dut_i (
    .core_clk_i   (core_clk_i),
    .arst_n_i     (arst_n_i),
    .io_clk_i     (io_clk_i),
    .io_data_i    (io_data_i),
    .io_valid_i   (io_valid_i),
    .io_token_r_o (io_token_r_o),
    .core_data_o  (core_data_o),
    .core_valid_o (core_valid_o),
    .core_yumi_i  (core_yumi_i)
  );

  initial
  begin
    core_clk_i = 1'b0;
    forever
    begin
      #(CORE_PERIOD / 2) core_clk_i = ~core_clk_i;
    end
  end

  // Transmitter model, one per channel
  for (genvar g = 0; g < NUM_CHANNELS; g++)
  begin : g_tx
    logic                     clk;
    logic [CHANNEL_WIDTH-1:0] data;
    logic                     valid;
    int                       sent_cnt = 0;
    int                       tok_cnt = 0;
    int                       tx_err = 0;

    assign io_clk_i[g]    = clk;
    assign io_data_i[g]   = data;
    assign io_valid_i[g]  = valid;
    assign tok_seen[g]    = tok_cnt;
    assign tx_err_seen[g] = tx_err;

    initial
    begin
      clk = 1'b0;
      #(IO_PHASE * g);
      forever
      begin
        #(IO_PERIOD / 2) clk = ~clk;
      end
    end

    // Every token toggle hands back a block of credits
    always @(io_token_r_o[g])
    begin
      if (arst_n_i === 1'b1)
      begin
        tok_cnt = tok_cnt + 1;
        // The sipo holds at most one packet and one partial beat beyond what the core took
        assert (TOKEN_BEATS * tok_cnt <= BEATS_PER_PACKET * (rx_count + 1) + 1)
        else
        begin
          tx_err = tx_err + 1;
          $display("Channel %0d returned token %0d before its beats were dequeued",
                   g, tok_cnt);
        end
      end
    end

    // Low byte is set up for the rising edge, high byte for the falling edge
    initial
    begin
      data  = '0;
      valid = 1'b0;
      forever
      begin
        @(negedge clk);
        #(DRIVE_DELAY);
        if (sent_cnt < tx_q[g].size() && sent_cnt < FIFO_DEPTH + TOKEN_BEATS * tok_cnt)
        begin
          data     = tx_q[g][sent_cnt][CHANNEL_WIDTH-1:0];
          valid    = 1'b1;
          sent_cnt = sent_cnt + 1;
          @(posedge clk);
          #(DRIVE_DELAY);
          data = tx_q[g][sent_cnt-1][DDR_WIDTH-1 -: CHANNEL_WIDTH];
        end
        else
        begin
          valid = 1'b0;
        end
      end
    end
  end

  // A presented packet stays put until the core takes it
  assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
                   core_valid_o && !core_yumi_i |=> core_valid_o && $stable(core_data_o))
  else
  begin
    hold_err = hold_err + 1;
    $display("%s: packet dropped or changed before the core took it", test_name);
  end

  // Core sink decides yumi after the outputs have settled past the edge
  initial
  begin
    logic take;
    logic rand_bit;
    int   yumi_seed;
    yumi_seed   = SEED;
    core_yumi_i = 1'b0;
    forever
    begin
      @(posedge core_clk_i);
      #(DRIVE_DELAY);
      rand_bit = 1'($random(yumi_seed));
      take     = arst_n_i && core_valid_o &&
                 (yumi_mode == YUMI_ALWAYS || (yumi_mode == YUMI_RANDOM && rand_bit));
      if (take)
      begin
        assert (rx_count < exp_q.size())
        else
        begin
          rx_err = rx_err + 1;
          $display("%s: core received a packet that was never sent", test_name);
        end
        assert (rx_count >= exp_q.size() || core_data_o == exp_q[rx_count])
        else
        begin
          rx_err = rx_err + 1;
          $display("CHECK FAILED %s: expected %h actual %h",
                   test_name, exp_q[rx_count], core_data_o);
        end
        rx_count = rx_count + 1;
      end
      core_yumi_i = take;
    end
  end

  function automatic int total_errors();
    int sum;
    sum = rx_err + hold_err + main_err;
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      sum += tx_err_seen[c];
    end
    return sum;
  endfunction

  task automatic end_test(input string name, input int err_before);
    int errs;
    errs = total_errors() - err_before;
    tests_run++;
    $display("Test %s %s with %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
  endtask

  // Beat b of a packet sits at 32*b, channel c inside it at 16*c
  task automatic load_packets(input int n, input int late_ch, input int lag);
    int                      base;
    logic [PACKET_WIDTH-1:0] pkt;
    base = exp_q.size();
    for (int p = 0; p < n; p++)
    begin
      pkt = '0;
      for (int w = 0; w < PACKET_WIDTH / 32; w++)
      begin
        pkt[w*32 +: 32] = $random(seed);
      end
      exp_q.push_back(pkt);
    end
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      if (c == late_ch)
      begin
        #(lag * IO_PERIOD);
      end
      for (int p = base; p < base + n; p++)
      begin
        for (int b = 0; b < BEATS_PER_PACKET; b++)
        begin
          tx_q[c].push_back(exp_q[p][(b * NUM_CHANNELS + c) * DDR_WIDTH +: DDR_WIDTH]);
        end
      end
    end
  endtask

  task automatic run_packets(input string name, input int n, input int mode,
                             input int late_ch, input int lag, input int hold);
    int err_before;
    int target;
    test_name  = name;
    err_before = total_errors();
    @(posedge core_clk_i);
    yumi_mode = (hold > 0) ? YUMI_HOLD : mode;
    load_packets(n, late_ch, lag);
    target = exp_q.size();
    if (hold > 0)
    begin
      repeat (hold) @(posedge core_clk_i);
      yumi_mode = mode;
    end
    wait (rx_count == target);
    end_test(name, err_before);
  endtask

  initial
  begin
    int err_before;
    arst_n_i   = 1'b0;
    err_before = total_errors();
    // Quiet outputs in reset and before any traffic
    for (int cyc = 0; cyc < 12; cyc++)
    begin
      @(posedge core_clk_i);
      #(DRIVE_DELAY);
      if (cyc == 7)
      begin
        arst_n_i = 1'b1;
      end
      assert (!core_valid_o && io_token_r_o == '0)
      else
      begin
        main_err++;
        $display("CHECK FAILED reset: expected valid 0 tokens 0 actual valid %b tokens %b",
                 core_valid_o, io_token_r_o);
      end
    end
    end_test("reset", err_before);

    run_packets("assembly", ASSEMBLY_PACKETS, YUMI_ALWAYS, -1, 0, 0);
    run_packets("skew", SKEW_PACKETS, YUMI_ALWAYS, NUM_CHANNELS - 1, 5, 0);
    run_packets("backpressure", HOLD_PACKETS, YUMI_ALWAYS, -1, 0, HOLD_CYCLES);
    run_packets("random_yumi", RANDOM_PACKETS, YUMI_RANDOM, -1, 0, 0);

    // Token toggles land within a few io cycles of the last dequeue
    test_name  = "token_rate";
    err_before = total_errors();
    #(4 * IO_PERIOD);
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      assert (tok_seen[c] == rx_count * BEATS_PER_PACKET / TOKEN_BEATS)
      else
      begin
        main_err++;
        $display("CHECK FAILED token_rate: channel %0d expected %0d actual %0d",
                 c, rx_count * BEATS_PER_PACKET / TOKEN_BEATS, tok_seen[c]);
      end
    end
    end_test("token_rate", err_before);

    $display("Tests run %0d, packets %0d, errors %0d", tests_run, rx_count, total_errors());
    if (total_errors() == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired in test %s before all packets arrived", test_name);
    $display("Finished with errors");
    $finish;
  end

endmodule
